// File: all.f
+incdir+testbench
verilog/regfile_pkg.sv
verilog/bank_req_if.sv
verilog/axi_lite_ctrl.sv
verilog/reg_bank.sv
verilog/read_return.sv
verilog/axi_regfile_top.sv
testbench/tb_axi_regfile.sv

// File: testbench/regfile_trace.txt
# op addr data strb exp_resp exp_rdata name (numbers in hex)
# W uses data and strb, R uses exp_rdata; unused columns are zero
R 00 00000000 0 0 00000000 rst_00
R 04 00000000 0 0 00000000 rst_04
R 08 00000000 0 0 00000000 rst_08
R 0c 00000000 0 0 00000000 rst_0c
R 10 00000000 0 0 00000000 rst_10
R 14 00000000 0 0 00000000 rst_14
R 18 00000000 0 0 00000000 rst_18
R 1c 00000000 0 0 00000000 rst_1c
R 20 00000000 0 0 00000000 rst_20
R 24 00000000 0 0 00000000 rst_24
R 28 00000000 0 0 00000000 rst_28
R 2c 00000000 0 0 00000000 rst_2c
R 30 00000000 0 0 00000000 rst_30
R 34 00000000 0 0 00000000 rst_34
R 38 00000000 0 0 00000000 rst_38
R 3c 00000000 0 0 00000000 rst_3c
W 00 a5005aff f 0 00000000 wr_00
W 04 a5045afb f 0 00000000 wr_04
W 08 a5085af7 f 0 00000000 wr_08
W 0c a50c5af3 f 0 00000000 wr_0c
W 10 a5105aef f 0 00000000 wr_10
W 14 a5145aeb f 0 00000000 wr_14
W 18 a5185ae7 f 0 00000000 wr_18
W 1c a51c5ae3 f 0 00000000 wr_1c
W 20 a5205adf f 0 00000000 wr_20
W 24 a5245adb f 0 00000000 wr_24
W 28 a5285ad7 f 0 00000000 wr_28
W 2c a52c5ad3 f 0 00000000 wr_2c
W 30 a5305acf f 0 00000000 wr_30
W 34 a5345acb f 0 00000000 wr_34
W 38 a5385ac7 f 0 00000000 wr_38
W 3c a53c5ac3 f 0 00000000 wr_3c
R 00 00000000 0 0 a5005aff rb_00
R 04 00000000 0 0 a5045afb rb_04
R 08 00000000 0 0 a5085af7 rb_08
R 0c 00000000 0 0 a50c5af3 rb_0c
R 10 00000000 0 0 a5105aef rb_10
R 14 00000000 0 0 a5145aeb rb_14
R 18 00000000 0 0 a5185ae7 rb_18
R 1c 00000000 0 0 a51c5ae3 rb_1c
R 20 00000000 0 0 a5205adf rb_20
R 24 00000000 0 0 a5245adb rb_24
R 28 00000000 0 0 a5285ad7 rb_28
R 2c 00000000 0 0 a52c5ad3 rb_2c
R 30 00000000 0 0 a5305acf rb_30
R 34 00000000 0 0 a5345acb rb_34
R 38 00000000 0 0 a5385ac7 rb_38
R 3c 00000000 0 0 a53c5ac3 rb_3c
W 14 11223344 5 0 00000000 part_wr_14
R 14 00000000 0 0 a5225a44 part_rd_14
W 28 99887766 a 0 00000000 part_wr_28
R 28 00000000 0 0 992877d7 part_rd_28
W 40 ffffffff f 2 00000000 bad_wr_40
R 40 00000000 0 2 deadbeef bad_rd_40
R 00 00000000 0 0 a5005aff alias_rd_00
W 06 00000000 f 2 00000000 mis_wr_06
R 06 00000000 0 2 deadbeef mis_rd_06
R 04 00000000 0 0 a5045afb alias_rd_04

// File: testbench/axi_master_tasks.svh
`ifndef AXI_MASTER_TASKS_SVH
`define AXI_MASTER_TASKS_SVH

// 0 to 3 cycles of response back-pressure
function automatic int pick_delay();
    return {$random(seed)} % 4;
endfunction

// call right after a rising edge, returns right after one
task automatic write_access(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input string name,
                            output logic [1:0] resp);
    int hold;
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    do @(posedge clk); while (!awready);
    awvalid <= 1'b0;
    do @(posedge clk); while (!wready);
    wvalid <= 1'b0;
    do @(posedge clk); while (!bvalid);
    resp = bresp;
    hold = pick_delay();
    repeat (hold) begin
        @(posedge clk);
        assert (bvalid && bresp == resp)
            else stop_with_error($sformatf("write response in %s changed before bready", name));
    end
    bready <= 1'b1;
    @(posedge clk);                                 // handshake edge
    assert (bvalid && bresp == resp)
        else stop_with_error($sformatf("write response in %s lost at bready", name));
    bready <= 1'b0;
    @(posedge clk);
    assert (!bvalid)
        else stop_with_error($sformatf("write response in %s arrived twice", name));
endtask

task automatic read_access(input logic [31:0] addr, input string name,
                           output logic [1:0] resp, output logic [31:0] data);
    int hold;
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    do @(posedge clk); while (!rvalid);
    resp = rresp;
    data = rdata;
    hold = pick_delay();
    repeat (hold) begin
        @(posedge clk);
        assert (rvalid && rresp == resp && rdata == data)
            else stop_with_error($sformatf("read response in %s changed before rready", name));
    end
    rready <= 1'b1;
    @(posedge clk);
    assert (rvalid && rresp == resp && rdata == data)
        else stop_with_error($sformatf("read response in %s lost at rready", name));
    rready <= 1'b0;
    @(posedge clk);
    assert (!rvalid)
        else stop_with_error($sformatf("read response in %s arrived twice", name));
endtask

`endif

// File: testbench/tb_axi_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_regfile;

    logic        clk;
    logic        rst_n;

    logic        awvalid;
    logic [31:0] awaddr;
    logic        awready;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        bready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rready;

    int seed = 32'h4b6c;
    int cycle_count = 0;
    int cycle_limit = 0;                // set once the trace is loaded

    // trace columns, one entry per line
    bit          wr_q    [$];
    logic [31:0] addr_q  [$];
    logic [31:0] data_q  [$];
    logic [3:0]  strb_q  [$];
    logic [1:0]  resp_q  [$];
    logic [31:0] rdata_q [$];
    string       name_q  [$];

    axi_regfile_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rready  (rready)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    // map is 0x00..0x3c, word aligned only
    function automatic bit addr_is_mapped(input logic [31:0] addr);
        return (addr <= 32'h3c) && (addr[1:0] == 2'b00);
    endfunction

    `include "axi_master_tasks.svh"

    task automatic load_trace();
        int    fd;
        int    fields;
        string line;
        string op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  resp;
        logic [31:0] exp_data;
        string       name;
        fd = $fopen("testbench/regfile_trace.txt", "r");
        assert (fd != 0) else stop_with_error("cannot open testbench/regfile_trace.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;                                   // comment or blank
            fields = $sscanf(line, "%s %h %h %h %h %h %s",
                             op, addr, data, strb, resp, exp_data, name);
            assert (fields == 7 && (op == "W" || op == "R"))
                else stop_with_error($sformatf("malformed trace line: %s", line));
            wr_q.push_back(op == "W");
            addr_q.push_back(addr);
            data_q.push_back(data);
            strb_q.push_back(strb);
            resp_q.push_back(resp);
            rdata_q.push_back(exp_data);
            name_q.push_back(name);
        end
        $fclose(fd);
    endtask

    // hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
            stop_with_error($sformatf("run timed out after %0d cycles", cycle_count));
    end

    initial begin
        logic [1:0]  got_resp;
        logic [31:0] got_data;
        logic [1:0]  rule_resp;
        rst_n   <= 1'b0;
        awvalid <= 1'b0;
        awaddr  <= '0;
        wvalid  <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        bready  <= 1'b0;
        arvalid <= 1'b0;
        araddr  <= '0;
        rready  <= 1'b0;
        load_trace();
        cycle_limit = 5 + 20 * wr_q.size();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < wr_q.size(); i++) begin
            rule_resp = addr_is_mapped(addr_q[i]) ? regfile_pkg::RESP_OKAY
                                                  : regfile_pkg::RESP_SLVERR;
            assert (rule_resp == resp_q[i]) else stop_with_error(
                $sformatf("trace entry %s expects a response that does not fit its address",
                          name_q[i]));
            if (wr_q[i]) begin
                write_access(addr_q[i], data_q[i], strb_q[i], name_q[i], got_resp);
                assert (got_resp == resp_q[i]) else stop_with_error(
                    $sformatf("Mismatch in %s: bresp expected %h, actual %h",
                              name_q[i], resp_q[i], got_resp));
            end else begin
                read_access(addr_q[i], name_q[i], got_resp, got_data);
                assert (got_resp == resp_q[i]) else stop_with_error(
                    $sformatf("Mismatch in %s: rresp expected %h, actual %h",
                              name_q[i], resp_q[i], got_resp));
                assert (got_data == rdata_q[i]) else stop_with_error(
                    $sformatf("Mismatch in %s: rdata expected %h, actual %h",
                              name_q[i], rdata_q[i], got_data));
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/axi_lite_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module axi_lite_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,

    // write address / data / response
    input  logic                              awvalid,
    input  logic [regfile_pkg::ADDR_W-1:0]    awaddr,
    output logic                              awready,
    input  logic                              wvalid,
    input  logic [regfile_pkg::DATA_W-1:0]    wdata,
    input  logic [regfile_pkg::STRB_W-1:0]    wstrb,
    output logic                              wready,
    output logic                              bvalid,
    output logic [1:0]                        bresp,
    input  logic                              bready,

    // read address / data
    input  logic                              arvalid,
    input  logic [regfile_pkg::ADDR_W-1:0]    araddr,
    output logic                              arready,
    output logic                              rvalid,
    input  logic                              rready,

    bank_req_if.ctrl                          req,
    output logic                              rd_addr_ok
);

    logic [1:0] w_state;
    logic [1:0] r_state;

    regfile_pkg::reg_addr_u waddr;
    regfile_pkg::reg_addr_u raddr;

    logic [regfile_pkg::DATA_W-1:0] wdata_q;
    logic [regfile_pkg::STRB_W-1:0] wstrb_q;

    logic w_ok;
    logic r_ok;

    // inside the map means no upper bits and no byte offset
    function automatic logic addr_in_map(regfile_pkg::reg_addr_u a);
        return (a.fields.upper == '0) && (a.fields.offset == '0);
    endfunction

    assign w_ok = addr_in_map(waddr);
    assign r_ok = addr_in_map(raddr);

    // write FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_state <= regfile_pkg::W_IDLE;
        end else begin
            case (w_state)
                regfile_pkg::W_IDLE: if (awvalid) w_state <= regfile_pkg::W_ADDR;
                regfile_pkg::W_ADDR: if (wvalid)  w_state <= regfile_pkg::W_DATA;
                regfile_pkg::W_DATA: w_state <= regfile_pkg::W_RESP;  // strobe cycle
                regfile_pkg::W_RESP: if (bready)  w_state <= regfile_pkg::W_IDLE;
                default:             w_state <= regfile_pkg::W_IDLE;
            endcase
        end
    end

    // read FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_state <= regfile_pkg::R_IDLE;
        end else begin
            case (r_state)
                regfile_pkg::R_IDLE: if (arvalid) r_state <= regfile_pkg::R_LOOK;
                regfile_pkg::R_LOOK: r_state <= regfile_pkg::R_DATA;  // read_return captures
                regfile_pkg::R_DATA: if (rready)  r_state <= regfile_pkg::R_IDLE;
                default:             r_state <= regfile_pkg::R_IDLE;
            endcase
        end
    end

    // address and write payload latches
    always_ff @(posedge clk) begin
        if (awvalid && awready)
            waddr.raw <= awaddr;
        if (wvalid && wready) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (arvalid && arready)
            raddr.raw <= araddr;
    end

    // AXI handshake outputs
    assign awready = (w_state == regfile_pkg::W_IDLE) && awvalid;
    assign wready  = (w_state == regfile_pkg::W_ADDR) && wvalid;
    assign bvalid  = (w_state == regfile_pkg::W_RESP);
    assign bresp   = w_ok ? regfile_pkg::RESP_OKAY : regfile_pkg::RESP_SLVERR;
    assign arready = (r_state == regfile_pkg::R_IDLE) && arvalid;
    assign rvalid  = (r_state == regfile_pkg::R_DATA);

    // bank strobes, bad addresses never reach a bank write
    assign req.wr_en = (w_state == regfile_pkg::W_DATA) && w_ok;
    assign req.rd_en = (r_state == regfile_pkg::R_LOOK);

    // read owns the select lines during its lookup cycle
    assign req.bank_sel = (r_state == regfile_pkg::R_LOOK) ? raddr.fields.bank
                                                           : waddr.fields.bank;
    assign req.index    = (r_state == regfile_pkg::R_LOOK) ? raddr.fields.index
                                                           : waddr.fields.index;
    assign req.wdata    = wdata_q;
    assign req.wstrb    = wstrb_q;

    assign rd_addr_ok = r_ok;

    // response held under back-pressure
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid
    );

endmodule

`default_nettype wire

// File: verilog/axi_regfile_top.sv
`timescale 1ns/100ps
`default_nettype none

module axi_regfile_top (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              awvalid,
    input  logic [regfile_pkg::ADDR_W-1:0]    awaddr,
    output logic                              awready,
    input  logic                              wvalid,
    input  logic [regfile_pkg::DATA_W-1:0]    wdata,
    input  logic [regfile_pkg::STRB_W-1:0]    wstrb,
    output logic                              wready,
    output logic                              bvalid,
    output logic [1:0]                        bresp,
    input  logic                              bready,

    input  logic                              arvalid,
    input  logic [regfile_pkg::ADDR_W-1:0]    araddr,
    output logic                              arready,
    output logic                              rvalid,
    output logic [regfile_pkg::DATA_W-1:0]    rdata,
    output logic [1:0]                        rresp,
    input  logic                              rready
);

    bank_req_if req ();

    logic rd_addr_ok;

    axi_lite_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bready     (bready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .req        (req),
        .rd_addr_ok (rd_addr_ok)
    );

    // one bank per generate slot, BANK_ID picks its rdata slot
    for (genvar g = 0; g < regfile_pkg::NUM_BANKS; g++) begin : g_bank
        reg_bank #(
            .BANK_ID (g)
        ) u_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (req)
        );
    end

    read_return u_read_return (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_en       (req.rd_en),
        .rd_addr_ok  (rd_addr_ok),
        .bank_sel    (req.bank_sel),
        .rdata_banks (req.rdata_banks),
        .rdata       (rdata),
        .rresp       (rresp)
    );

endmodule

`default_nettype wire

// File: verilog/bank_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface bank_req_if;

    logic                               wr_en;      // single cycle write strobe
    logic                               rd_en;      // single cycle read strobe
    logic [regfile_pkg::BANK_W-1:0]     bank_sel;
    logic [regfile_pkg::IDX_W-1:0]      index;
    logic [regfile_pkg::DATA_W-1:0]     wdata;
    logic [regfile_pkg::STRB_W-1:0]     wstrb;

    // one word per bank, each bank drives its own slot
    logic [regfile_pkg::DATA_W-1:0]     rdata_banks [regfile_pkg::NUM_BANKS];

    modport ctrl (
        output wr_en, rd_en, bank_sel, index, wdata, wstrb
    );

    modport bank (
        input  wr_en, rd_en, bank_sel, index, wdata, wstrb,
        output rdata_banks
    );

endinterface

`default_nettype wire

// File: verilog/read_return.sv
`timescale 1ns/100ps
`default_nettype none

module read_return (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              rd_en,
    input  logic                              rd_addr_ok,
    input  logic [regfile_pkg::BANK_W-1:0]    bank_sel,
    input  logic [regfile_pkg::DATA_W-1:0]    rdata_banks [regfile_pkg::NUM_BANKS],
    output logic [regfile_pkg::DATA_W-1:0]    rdata,
    output logic [1:0]                        rresp
);

    // capture once per read, hold while rready is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
            rresp <= regfile_pkg::RESP_OKAY;
        end else if (rd_en) begin
            if (rd_addr_ok) begin
                rdata <= rdata_banks[bank_sel];
                rresp <= regfile_pkg::RESP_OKAY;
            end else begin
                rdata <= regfile_pkg::ERR_WORD;     // outside the map
                rresp <= regfile_pkg::RESP_SLVERR;
            end
        end
    end

    // one lookup per accepted read address
    a_rd_en_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en |=> !rd_en
    );

endmodule

`default_nettype wire

// File: verilog/reg_bank.sv
`timescale 1ns/100ps
`default_nettype none

module reg_bank #(
    parameter int BANK_ID = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    bank_req_if.bank   req
);

    logic [regfile_pkg::DATA_W-1:0] regs [regfile_pkg::REGS_PER_BANK];
    logic                           hit;

    assign hit = req.wr_en && (req.bank_sel == regfile_pkg::BANK_W'(BANK_ID));

    // byte lane writes into the indexed register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < regfile_pkg::REGS_PER_BANK; r++) begin
                regs[r] <= '0;
            end
        end else if (hit) begin
            for (int b = 0; b < regfile_pkg::STRB_W; b++) begin
                if (req.wstrb[b])
                    regs[req.index][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    // read path is combinational, read_return does the selection
    assign req.rdata_banks[BANK_ID] = regs[req.index];

    // select lines are shared, so strobes must not collide
    a_no_rw_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(req.wr_en && req.rd_en)
    );

endmodule

`default_nettype wire

// File: verilog/regfile_pkg.sv
`default_nettype none

package regfile_pkg;

    localparam int ADDR_W        = 32;
    localparam int DATA_W        = 32;
    localparam int STRB_W        = DATA_W / 8;
    localparam int NUM_BANKS     = 4;
    localparam int REGS_PER_BANK = 4;
    localparam int BANK_W        = $clog2(NUM_BANKS);
    localparam int IDX_W         = $clog2(REGS_PER_BANK);
    localparam int OFFS_W        = 2;                            // byte offset in a word
    localparam int UPPER_W       = ADDR_W - BANK_W - IDX_W - OFFS_W;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [DATA_W-1:0] ERR_WORD = 32'hDEAD_BEEF;      // read data for a bad address

    // write channel FSM
    localparam logic [1:0] W_IDLE = 2'd0;
    localparam logic [1:0] W_ADDR = 2'd1;
    localparam logic [1:0] W_DATA = 2'd2;
    localparam logic [1:0] W_RESP = 2'd3;

    // read channel FSM
    localparam logic [1:0] R_IDLE = 2'd0;
    localparam logic [1:0] R_LOOK = 2'd1;
    localparam logic [1:0] R_DATA = 2'd2;

    // byte address as seen on the bus, or split into map fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [UPPER_W-1:0] upper;                           // zero inside the map
            logic [BANK_W-1:0]  bank;
            logic [IDX_W-1:0]   index;
            logic [OFFS_W-1:0]  offset;                          // zero when word aligned
        } fields;
    } reg_addr_u;

endpackage

`default_nettype wire
